// File: logic/grayFifoPkg.sv
package grayFifoPkg;

	// prefix-AND structure inside the Gray incrementer
	// serial is the smallest and slowest
	// Brent-Kung sits in the middle
	// Sklansky is the shallowest tree, with the highest fan-out
	typedef enum logic [1:0] {
		serialPrefix,
		brentKungPrefix,
		sklanskyPrefix
	} prefixArch_e;

	// FIFO occupancy flags, decided on the Gray pointers
	typedef struct packed {
		// pointers equal
		logic empty;
		// top two bits inverted, rest equal
		logic full;
	} fifoFlags_t;

endpackage

// File: logic/incGray.sv
`timescale 1ns/1ps

module incGray #(
	parameter int width = 8,
	parameter grayFifoPkg::prefixArch_e arch = grayFifoPkg::brentKungPrefix
) (
	input  logic [width-1:0] a,
	output logic [width-1:0] z
);
	import grayFifoPkg::*;

	// prefix inputs for every bit below the top
	logic [width-2:0] pi;
	// prefix outputs set when all lower bits are clear
	logic [width-2:0] po;
	// parity of the current code
	logic parity;
	// flip candidates before parity gating
	logic [width-1:1] run;
	// final flip mask
	logic [width-1:0] flip;

	redXor #(.width(width)) parityXor (
		.a(a),
		.z(parity)
	);

	// propagate while lower bits are zero
	assign pi[width-2:1] = ~a[width-3:0];

	// serial chain takes the late parity at its head
	if (arch == serialPrefix) begin : gParityIn
		assign pi[0] = parity;
	end else begin : gParityOut
		assign pi[0] = 1'b1;
	end

	prefixAnd #(
		.width(width - 1),
		.arch (arch)
	) prefixNet (
		.pi(pi),
		.po(po)
	);

	for (genvar i = 1; i < width; i++) begin : gFlip
		if (i == width - 1) begin : gTop
			// wrap when the lowest set bit is one of the top two
			assign run[i] = po[width-2];
		end else begin : gMid
			// bit just below is the lowest set bit
			assign run[i] = a[i-1] & po[i-1];
		end
		if (arch == serialPrefix) begin : gNoGate
			// parity already folded into the chain
			assign flip[i] = run[i];
		end else begin : gGate
			assign flip[i] = run[i] & parity;
		end
	end

	// even parity flips the lowest bit
	assign flip[0] = ~parity;

	assign z = a ^ flip;

endmodule

module prefixAnd #(
	parameter int width = 8,
	parameter grayFifoPkg::prefixArch_e arch = grayFifoPkg::brentKungPrefix
) (
	input  logic [width-1:0] pi,
	output logic [width-1:0] po
);
	import grayFifoPkg::*;

	// levels of a binary tree over the word
	localparam int depth = $clog2(width);

	if (arch == sklanskyPrefix) begin : gSklansky
		logic [depth:0][width-1:0] pt;

		assign pt[0] = pi;
		for (genvar l = 1; l <= depth; l++) begin : gLevel
			for (genvar i = 0; i < width; i++) begin : gBit
				// last bit of the lower half of this block
				localparam int src = ((i >> l) << l) + 2**(l-1) - 1;
				if (((i >> (l - 1)) & 1) == 1) begin : gNode
					assign pt[l][i] = pt[l-1][i] & pt[l-1][src];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		assign po = pt[depth];
	end else if (arch == brentKungPrefix) begin : gBrentKung
		// up-sweep takes depth levels and down-sweep one less
		localparam int stages = 2 * depth - 1;
		logic [stages:0][width-1:0] pt;

		assign pt[0] = pi;
		// up-sweep builds block totals at the end of each aligned block
		for (genvar l = 1; l <= depth; l++) begin : gUp
			for (genvar i = 0; i < width; i++) begin : gBit
				if (((i + 1) % (2**l)) == 0) begin : gNode
					assign pt[l][i] = pt[l-1][i] & pt[l-1][i - 2**(l-1)];
				end else begin : gPass
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end
		// down-sweep fills in the middle positions
		for (genvar d = depth + 1; d <= stages; d++) begin : gDown
			localparam int span = 2**(stages - d);
			for (genvar i = 0; i < width; i++) begin : gBit
				if (((i + 1) % (2 * span)) == span && i >= 2 * span) begin : gNode
					assign pt[d][i] = pt[d-1][i] & pt[d-1][i - span];
				end else begin : gPass
					assign pt[d][i] = pt[d-1][i];
				end
			end
		end
		assign po = pt[stages];
	end else begin : gSerial
		// ripple chain of width-1 gates
		logic [width-1:0] pt;

		assign pt[0] = pi[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign pt[i] = pi[i] & pt[i-1];
		end
		assign po = pt;
	end

endmodule

module redXor #(
	parameter int width = 8
) (
	input  logic [width-1:0] a,
	output logic             z
);

	logic acc;

	// XOR fold over all bits
	always_comb begin
		acc = a[0];
		for (int i = 1; i < width; i++) begin
			acc ^= a[i];
		end
		z = acc;
	end

endmodule

// File: logic/grayPointer.sv
`timescale 1ns/1ps

module grayPointer #(
	parameter int width = 4,
	parameter grayFifoPkg::prefixArch_e arch = grayFifoPkg::brentKungPrefix
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             advance,
	output logic [width-1:0] ptr
);

	// successor code, one bit away from ptr
	logic [width-1:0] nextPtr;

	incGray #(
		.width(width),
		.arch (arch)
	) increment (
		.a(ptr),
		.z(nextPtr)
	);

	// pointer register
	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else if (advance) begin
			ptr <= nextPtr;
		end
	end

endmodule

// File: logic/fifoStatus.sv
`timescale 1ns/1ps

module fifoStatus #(
	parameter int addrWidth = 3
) (
	input  logic [addrWidth:0]      writePtr,
	input  logic [addrWidth:0]      readPtr,
	output grayFifoPkg::fifoFlags_t flags,
	output logic [addrWidth:0]      level,
	output logic [addrWidth-1:0]    writeAddr,
	output logic [addrWidth-1:0]    readAddr
);

	// binary forms of both pointers
	logic [addrWidth:0] writeBin;
	logic [addrWidth:0] readBin;

	// prefix XOR from the top bit down
	function automatic logic [addrWidth:0] grayToBin(input logic [addrWidth:0] gray);
		logic [addrWidth:0] bin;
		bin[addrWidth] = gray[addrWidth];
		for (int i = addrWidth - 1; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

	assign writeBin = grayToBin(writePtr);
	assign readBin = grayToBin(readPtr);

	// low bits index the storage
	// the extra top bit only tells laps apart
	assign writeAddr = writeBin[addrWidth-1:0];
	assign readAddr = readBin[addrWidth-1:0];

	// wraps naturally at addrWidth+1 bits
	assign level = writeBin - readBin;

	// same lap, same slot
	assign flags.empty = (writePtr == readPtr);

	// one lap ahead, same slot
	// in Gray code that inverts the top two bits only
	assign flags.full = (writePtr[addrWidth -: 2] == ~readPtr[addrWidth -: 2]) &&
		(writePtr[addrWidth-2:0] == readPtr[addrWidth-2:0]);

endmodule

// File: logic/fifoStorage.sv
`timescale 1ns/1ps

module fifoStorage #(
	parameter int addrWidth = 3,
	parameter int dataWidth = 8
) (
	input  logic                 clk,
	input  logic                 write,
	input  logic [addrWidth-1:0] writeAddr,
	input  logic [dataWidth-1:0] writeData,
	input  logic [addrWidth-1:0] readAddr,
	output logic [dataWidth-1:0] readData
);

	// one entry per slot
	logic [dataWidth-1:0] mem [2**addrWidth];

	// write port, registered
	always_ff @(posedge clk) begin
		if (write) begin
			mem[writeAddr] <= writeData;
		end
	end

	// show-ahead read, straight from the array
	assign readData = mem[readAddr];

endmodule

// File: logic/grayFifo.sv
`timescale 1ns/1ps

module grayFifo #(
	parameter int addrWidth = 3,
	parameter int dataWidth = 8,
	parameter grayFifoPkg::prefixArch_e prefixArch = grayFifoPkg::brentKungPrefix
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    push,
	input  logic [dataWidth-1:0]    writeData,
	input  logic                    pop,
	output logic [dataWidth-1:0]    readData,
	output grayFifoPkg::fifoFlags_t flags,
	output logic [addrWidth:0]      level
);

	// Gray pointers, one extra bit for the lap
	logic [addrWidth:0] writePtr;
	logic [addrWidth:0] readPtr;
	// binary slot addresses
	logic [addrWidth-1:0] writeAddr;
	logic [addrWidth-1:0] readAddr;
	// strobes that actually take effect
	logic doPush;
	logic doPop;

	// drop push when full, ignore pop when empty
	assign doPush = push & ~flags.full;
	assign doPop = pop & ~flags.empty;

	grayPointer #(
		.width(addrWidth + 1),
		.arch (prefixArch)
	) writePointer (
		.clk    (clk),
		.reset  (reset),
		.advance(doPush),
		.ptr    (writePtr)
	);

	grayPointer #(
		.width(addrWidth + 1),
		.arch (prefixArch)
	) readPointer (
		.clk    (clk),
		.reset  (reset),
		.advance(doPop),
		.ptr    (readPtr)
	);

	// flags and level from registered pointers
	fifoStatus #(
		.addrWidth(addrWidth)
	) status (
		.writePtr (writePtr),
		.readPtr  (readPtr),
		.flags    (flags),
		.level    (level),
		.writeAddr(writeAddr),
		.readAddr (readAddr)
	);

	fifoStorage #(
		.addrWidth(addrWidth),
		.dataWidth(dataWidth)
	) storage (
		.clk      (clk),
		.write    (doPush),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readAddr (readAddr),
		.readData (readData)
	);

endmodule

// File: tb/grayFifoTb.sv
`timescale 1ns/1ps

module grayFifoTb;
	import grayFifoPkg::*;

	localparam int addrWidth = 3;
	localparam int dataWidth = 8;
	localparam int depth = 2**addrWidth;
	// cycles allowed for reset to come off
	localparam int resetTimeout = 20;
	// bound on lines read from the vector file
	localparam int maxVectorLines = 500;
	localparam int randomCycles = 400;

	logic                 clk = 1'b0;
	logic                 reset = 1'b1;
	logic                 push = 1'b0;
	logic                 pop = 1'b0;
	logic [dataWidth-1:0] writeData = '0;
	logic [dataWidth-1:0] readData;
	fifoFlags_t           flags;
	logic [addrWidth:0]   level;

	// reference queue with its head at index 0
	logic [dataWidth-1:0] model [$];
	int errorCount = 0;
	int vectorErrors = 0;
	int randomErrors = 0;
	int checkCount = 0;
	int vectorLines = 0;
	int seed = 63;
	bit timedOut = 1'b0;

	grayFifo #(
		.addrWidth (addrWidth),
		.dataWidth (dataWidth),
		.prefixArch(brentKungPrefix)
	) i_dut (
		.clk      (clk),
		.reset    (reset),
		.push     (push),
		.writeData(writeData),
		.pop      (pop),
		.readData (readData),
		.flags    (flags),
		.level    (level)
	);

	// 8 ns period
	always #4 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("Error: %0t, %s expected %0h, actual %0h",
				$realtime, name, expected, actual);
		end
	endtask

	// compare all outputs against one expected state
	task automatic checkOutputs(input logic expEmpty, input logic expFull,
		input logic [addrWidth:0] expLevel, input logic checkData,
		input logic [dataWidth-1:0] expData);
		checkValue("flags.empty", 32'(expEmpty), 32'(flags.empty));
		checkValue("flags.full", 32'(expFull), 32'(flags.full));
		checkValue("level", 32'(expLevel), 32'(level));
		// readData only means something while not empty
		if (checkData) begin
			checkValue("readData", 32'(expData), 32'(readData));
		end
	endtask

	// one ASCII hex digit with a valid flag on top
	function automatic logic [4:0] hexDigit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'b0;
		if (c >= 8'h30 && c <= 8'h39) begin
			r = {1'b1, c[3:0]};
		end else if ((c >= 8'h61 && c <= 8'h66) || (c >= 8'h41 && c <= 8'h46)) begin
			r = {1'b1, c[3:0] + 4'd9};
		end
		return r;
	endfunction

	task automatic applyReset();
		int waited;
		@(posedge clk);
		reset <= 1'b1;
		push <= 1'b0;
		pop <= 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		waited = 0;
		// wait until reset is off and the FIFO reads empty
		while ((reset !== 1'b0 || flags.empty !== 1'b1) && waited < resetTimeout) begin
			@(posedge clk);
			waited++;
		end
		if (reset !== 1'b0 || flags.empty !== 1'b1) begin
			$display("Timeout: the FIFO did not come out of reset within %0d cycles",
				resetTimeout);
			timedOut = 1'b1;
		end else begin
			@(negedge clk);
			// fresh state straight out of reset
			checkOutputs(1'b1, 1'b0, '0, 1'b0, '0);
		end
	endtask

	task automatic runVectors();
		int fd;
		int code;
		int lines;
		logic [8*96-1:0] lineBuf;
		logic [31:0] vPush;
		logic [31:0] vPop;
		logic [31:0] vData;
		logic [31:0] vEmpty;
		logic [31:0] vFull;
		logic [31:0] vLevel;
		logic [15:0] dataTok;
		logic [4:0] hi;
		logic [4:0] lo;
		fd = $fopen("tb/grayFifoVectors.txt", "r");
		if (fd == 0) begin
			$display("The vector file tb/grayFifoVectors.txt could not be opened");
			errorCount++;
		end else begin
			lines = 0;
			while (!$feof(fd) && lines < maxVectorLines) begin
				lines++;
				lineBuf = '0;
				dataTok = '0;
				code = $fgets(lineBuf, fd);
				code = $sscanf(lineBuf, "%h %h %h %h %h %h %s",
					vPush, vPop, vData, vEmpty, vFull, vLevel, dataTok);
				// comment and blank lines fail the scan and are skipped
				if (code == 7) begin
					@(posedge clk);
					push <= vPush[0];
					pop <= vPop[0];
					writeData <= vData[dataWidth-1:0];
					@(negedge clk);
					// expected columns are the state before this line's strobes
					hi = hexDigit(dataTok[15:8]);
					lo = hexDigit(dataTok[7:0]);
					if (dataTok == 16'h2d2d) begin
						checkOutputs(vEmpty[0], vFull[0], vLevel[addrWidth:0], 1'b0, '0);
					end else if (hi[4] && lo[4]) begin
						checkOutputs(vEmpty[0], vFull[0], vLevel[addrWidth:0], 1'b1,
							{hi[3:0], lo[3:0]});
					end else begin
						$display("Vector line %0d has an unreadable readData field", lines);
						errorCount++;
					end
					vectorLines++;
				end
			end
			if (!$feof(fd)) begin
				$display("Timeout: the vector file did not end within %0d lines",
					maxVectorLines);
				timedOut = 1'b1;
			end
			$fclose(fd);
			@(posedge clk);
			push <= 1'b0;
			pop <= 1'b0;
			if (vectorLines == 0) begin
				$display("The vector file held no usable vectors");
				errorCount++;
			end
		end
	endtask

	task automatic runRandom();
		logic rPush;
		logic rPop;
		logic [dataWidth-1:0] rData;
		logic wasFull;
		logic wasEmpty;
		for (int n = 0; n < randomCycles; n++) begin
			// fill-heavy, then drain-heavy, then balanced
			if (n < 100) begin
				rPush = ($random(seed) & 3) != 0;
				rPop = ($random(seed) & 3) == 0;
			end else if (n < 200) begin
				rPush = ($random(seed) & 3) == 0;
				rPop = ($random(seed) & 3) != 0;
			end else begin
				rPush = ($random(seed) & 1) != 0;
				rPop = ($random(seed) & 1) != 0;
			end
			rData = 8'($random(seed));
			@(posedge clk);
			push <= rPush;
			pop <= rPop;
			writeData <= rData;
			@(negedge clk);
			wasEmpty = model.size() == 0;
			wasFull = model.size() == depth;
			checkOutputs(wasEmpty, wasFull, (addrWidth + 1)'(model.size()), !wasEmpty,
				wasEmpty ? '0 : model[0]);
			// strobes act on the state before the edge
			if (rPop && !wasEmpty) begin
				void'(model.pop_front());
			end
			if (rPush && !wasFull) begin
				model.push_back(rData);
			end
		end
		@(posedge clk);
		push <= 1'b0;
		pop <= 1'b0;
		@(negedge clk);
		// the last random strobes have taken effect by now
		wasEmpty = model.size() == 0;
		wasFull = model.size() == depth;
		checkOutputs(wasEmpty, wasFull, (addrWidth + 1)'(model.size()), !wasEmpty,
			wasEmpty ? '0 : model[0]);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		applyReset();
		if (!timedOut) begin
			runVectors();
			vectorErrors = errorCount;
		end
		// start the random phase from an empty FIFO
		if (!timedOut) begin
			applyReset();
		end
		if (!timedOut) begin
			runRandom();
		end
		randomErrors = errorCount - vectorErrors;
		$display("vector errors %0d, random errors %0d, total errors %0d in %0d checks",
			vectorErrors, randomErrors, errorCount, checkCount);
		if (errorCount == 0 && !timedOut) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: tb/grayFifoVectors.txt
# columns: push pop writeData | expected empty full level readData, all hex
# expected values are the state before the line's strobes, -- means FIFO empty
0 0 00 1 0 0 --
0 1 00 1 0 0 --   pop while empty
1 0 11 1 0 0 --
1 0 22 0 0 1 11
1 0 33 0 0 2 11
1 0 44 0 0 3 11
1 0 55 0 0 4 11
1 0 66 0 0 5 11
1 0 77 0 0 6 11
1 0 88 0 0 7 11
1 0 99 0 1 8 11   push while full is dropped
0 0 00 0 1 8 11
0 1 00 0 1 8 11
0 1 00 0 0 7 22
0 1 00 0 0 6 33
0 1 00 0 0 5 44
0 1 00 0 0 4 55
0 1 00 0 0 3 66
0 1 00 0 0 2 77
0 1 00 0 0 1 88
0 1 00 1 0 0 --   pop while empty
0 0 00 1 0 0 --
1 0 a0 1 0 0 --
1 0 a1 0 0 1 a0
1 1 b0 0 0 2 a0   push and pop together
1 1 b1 0 0 2 a1
1 1 b2 0 0 2 b0
1 1 b3 0 0 2 b1
1 1 b4 0 0 2 b2
1 1 b5 0 0 2 b3
1 1 b6 0 0 2 b4
1 1 b7 0 0 2 b5
1 1 c0 0 0 2 b6
1 1 c1 0 0 2 b7
1 1 c2 0 0 2 c0
1 1 c3 0 0 2 c1
0 1 00 0 0 2 c2
0 1 00 0 0 1 c3
1 1 d0 1 0 0 --   pop ignored, push taken
0 0 00 0 0 1 d0
1 0 e1 0 0 1 d0
1 0 e2 0 0 2 d0
1 0 e3 0 0 3 d0
1 0 e4 0 0 4 d0
1 0 e5 0 0 5 d0
1 0 e6 0 0 6 d0
1 0 e7 0 0 7 d0
1 1 f0 0 1 8 d0   full after wrap, push dropped, pop taken
0 0 00 0 0 7 e1

// File: grayFifo.f
logic/grayFifoPkg.sv
logic/incGray.sv
logic/grayPointer.sv
logic/fifoStatus.sv
logic/fifoStorage.sv
logic/grayFifo.sv
tb/grayFifoTb.sv

// File: Makefile
TOP := grayFifoTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f grayFifo.f --top-module grayFifo

sim:
	verilator --binary --timing --assert -f grayFifo.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
